//--- verilog/bringup_pkg.sv
// shared widths and report characters; pin count must stay a power of two for the scanner select
package bringup_pkg;

	localparam int NUM_PINS = 16;                 // sensed pins in the bank

	typedef logic [NUM_PINS-1:0] pin_vec_t;       // one bit per pin, bit 0 first
	typedef logic [7:0] byte_t;                   // uart data byte

	// activity counter reload, in decay ticks
	localparam int ACTIVITY_MAX = 7;

	typedef logic [$clog2(ACTIVITY_MAX+1)-1:0] activity_t;

	// report line characters
	localparam byte_t CHAR_ACTIVE = 8'h31;        // "1"
	localparam byte_t CHAR_IDLE = 8'h2e;          // "."
	localparam byte_t CHAR_CR = 8'h0d;
	localparam byte_t CHAR_LF = 8'h0a;

	// one char per pin plus cr lf
	localparam int REPORT_LEN = NUM_PINS + 2;

	typedef logic [$clog2(REPORT_LEN)-1:0] report_idx_t;

	// default timing for a 12 MHz board clock
	localparam int DEFAULT_CLOCKS_PER_DEC = 12000;      // 1 kHz decay
	localparam int DEFAULT_CLOCKS_PER_SCAN = 1200000;   // 10 Hz reports
	localparam int DEFAULT_CLOCKS_PER_BAUD = 104;       // 115200 baud
	localparam int DEFAULT_DRIVER_HALF = 6000;          // 1 kHz square wave

	typedef enum logic [1:0] {
		IDLE,        // waiting for a scan tick
		SEND,        // write strobe for the current byte
		WAIT_BUSY,   // uart has not yet raised busy
		WAIT_IDLE    // frame in flight
	} scanner_state_t;

endpackage

//--- verilog/pulse.sv
// one-cycle tick every CLOCKS_PER_PULSE cycles; first tick CLOCKS_PER_PULSE cycles after reset
`default_nettype none

module pulse #(
	parameter int CLOCKS_PER_PULSE = 12000
) (
	input  wire  clock,
	input  wire  rst_n_i,
	output logic pulse_o
);

	typedef logic [$clog2(CLOCKS_PER_PULSE+1)-1:0] count_t;

	count_t count;

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			count <= count_t'(CLOCKS_PER_PULSE - 1);
			pulse_o <= 1'b0;
		end else if (count == '0) begin
			count <= count_t'(CLOCKS_PER_PULSE - 1);   // reload
			pulse_o <= 1'b1;
		end else begin
			count <= count - 1'b1;
			pulse_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/bringup_driver.sv
// square wave on the loopback pin, period 2*DRIVER_HALF cycles, low out of reset
`default_nettype none

module bringup_driver #(
	parameter int DRIVER_HALF = 6000
) (
	input  wire  clock,
	input  wire  rst_n_i,
	output logic drive_o
);

	typedef logic [$clog2(DRIVER_HALF+1)-1:0] half_t;

	half_t count;

	// invert once per half period so the far-side sensor always sees edges
	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			count <= half_t'(DRIVER_HALF - 1);
			drive_o <= 1'b0;
		end else if (count == '0) begin
			count <= half_t'(DRIVER_HALF - 1);
			drive_o <= ~drive_o;                  // half period done
		end else begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/bringup_sensor.sv
// pin activity detector; mark lags a pin edge by 3 cycles and drops ACTIVITY_MAX decay ticks later
`default_nettype none

module bringup_sensor (
	input  wire  clock,
	input  wire  rst_n_i,
	input  wire  pin_i,
	input  wire  dec_i,
	output logic sensed_o
);

	logic sync1;
	logic sync2;
	logic prev;
	logic edge_seen;
	bringup_pkg::activity_t activity;

	// pin is asynchronous to clock
	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			sync1 <= 1'b0;
			sync2 <= 1'b0;
			prev <= 1'b0;
		end else begin
			sync1 <= pin_i;
			sync2 <= sync1;
			prev <= sync2;                        // edge register
		end
	end

	assign edge_seen = sync2 ^ prev;           // either direction counts

	// an edge wins over a decay tick in the same cycle
	always_ff @(posedge clock) begin
		if (!rst_n_i)
			activity <= '0;
		else if (edge_seen)
			activity <= bringup_pkg::activity_t'(bringup_pkg::ACTIVITY_MAX);
		else if (dec_i && activity != '0)
			activity <= activity - 1'b1;
	end

	assign sensed_o = (activity != '0);

endmodule

`default_nettype wire

//--- verilog/bringup_scanner.sv
// report builder; scan ticks during a running report are dropped, the uart paces the bytes
`default_nettype none

module bringup_scanner (
	input  wire                    clock,
	input  wire                    rst_n_i,
	input  wire                    pulse_i,
	input  bringup_pkg::pin_vec_t  state_i,
	input  wire                    hold_i,
	output logic                   write_o,
	output bringup_pkg::byte_t     data_o
);

	bringup_pkg::scanner_state_t state;
	bringup_pkg::pin_vec_t snapshot;
	bringup_pkg::report_idx_t index;
	logic last_byte;

	assign last_byte = (index == bringup_pkg::report_idx_t'(bringup_pkg::REPORT_LEN - 1));

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			state <= bringup_pkg::IDLE;
			index <= '0;
		end else begin
			case (state)
				bringup_pkg::IDLE: begin
					if (pulse_i) begin
						index <= '0;
						state <= bringup_pkg::SEND;
					end
				end
				bringup_pkg::SEND: begin
					if (!hold_i)
						state <= bringup_pkg::WAIT_BUSY;   // byte taken by the uart
				end
				bringup_pkg::WAIT_BUSY: begin
					if (hold_i)
						state <= bringup_pkg::WAIT_IDLE;
				end
				bringup_pkg::WAIT_IDLE: begin
					if (!hold_i) begin
						if (last_byte) begin
							state <= bringup_pkg::IDLE;     // line complete
						end else begin
							index <= index + 1'b1;
							state <= bringup_pkg::SEND;
						end
					end
				end
				default: state <= bringup_pkg::IDLE;
			endcase
		end
	end

	// marks are frozen for the whole line
	always_ff @(posedge clock) begin
		if (state == bringup_pkg::IDLE && pulse_i)
			snapshot <= state_i;
	end

	// strobe lasts the single SEND cycle
	assign write_o = (state == bringup_pkg::SEND) && !hold_i;

	// pins from 0 upward, then the line end
	always_comb begin
		if (index < bringup_pkg::report_idx_t'(bringup_pkg::NUM_PINS)) begin
			if (snapshot[index[$clog2(bringup_pkg::NUM_PINS)-1:0]])
				data_o = bringup_pkg::CHAR_ACTIVE;
			else
				data_o = bringup_pkg::CHAR_IDLE;
		end else if (index == bringup_pkg::report_idx_t'(bringup_pkg::NUM_PINS)) begin
			data_o = bringup_pkg::CHAR_CR;
		end else begin
			data_o = bringup_pkg::CHAR_LF;
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
// 8N1 transmitter; a write while busy is ignored, busy covers the stop bit
`default_nettype none

module uart_tx #(
	parameter int CLOCKS_PER_BAUD = 104
) (
	input  wire                 clock,
	input  wire                 rst_n_i,
	input  wire                 write_i,
	input  bringup_pkg::byte_t  data_i,
	output logic                busy_o,
	output logic                tx_o
);

	typedef logic [$clog2(CLOCKS_PER_BAUD+1)-1:0] baud_t;
	typedef logic [3:0] bit_idx_t;

	logic [9:0] shifter;                       // stop, data msb..lsb, start
	baud_t baud_count;
	bit_idx_t bit_count;

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			shifter <= '1;                        // line idles high
			baud_count <= '0;
			bit_count <= '0;
			busy_o <= 1'b0;
		end else if (!busy_o) begin
			if (write_i) begin
				shifter <= {1'b1, data_i, 1'b0};
				baud_count <= baud_t'(CLOCKS_PER_BAUD - 1);
				bit_count <= '0;
				busy_o <= 1'b1;
			end
		end else if (baud_count == '0) begin
			// bit time over, move to the next bit
			shifter <= {1'b1, shifter[9:1]};
			baud_count <= baud_t'(CLOCKS_PER_BAUD - 1);
			bit_count <= bit_count + 1'b1;
			if (bit_count == bit_idx_t'(9))
				busy_o <= 1'b0;                     // stop bit done
		end else begin
			baud_count <= baud_count - 1'b1;
		end
	end

	assign tx_o = shifter[0];

endmodule

`default_nettype wire

//--- verilog/bringup_levelshifter.sv
// level shifter tester top; pin NUM_PINS-1 is meant to be looped back from drive_o on the board
`default_nettype none

module bringup_levelshifter #(
	parameter int CLOCKS_PER_DEC = bringup_pkg::DEFAULT_CLOCKS_PER_DEC,
	parameter int CLOCKS_PER_SCAN = bringup_pkg::DEFAULT_CLOCKS_PER_SCAN,
	parameter int CLOCKS_PER_BAUD = bringup_pkg::DEFAULT_CLOCKS_PER_BAUD,
	parameter int DRIVER_HALF = bringup_pkg::DEFAULT_DRIVER_HALF
) (
	input  wire                    clock,
	input  wire                    rst_n_i,
	input  bringup_pkg::pin_vec_t  sense_i,
	output logic                   drive_o,
	output logic                   uart_tx_o
);

	logic dec;
	logic scan_pulse;
	bringup_pkg::pin_vec_t sensor_state;
	logic uart_write;
	bringup_pkg::byte_t uart_data;
	logic uart_busy;

	bringup_driver #(.DRIVER_HALF(DRIVER_HALF)) driver0 (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.drive_o(drive_o));

	// decay must stay slower than the driver toggle
	pulse #(.CLOCKS_PER_PULSE(CLOCKS_PER_DEC)) pulse_dec (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.pulse_o(dec));

	pulse #(.CLOCKS_PER_PULSE(CLOCKS_PER_SCAN)) pulse_scan (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.pulse_o(scan_pulse));

	for (genvar i = 0; i < bringup_pkg::NUM_PINS; i++) begin : gen_sensor
		bringup_sensor sensor0 (
			.clock(clock),
			.rst_n_i(rst_n_i),
			.pin_i(sense_i[i]),
			.dec_i(dec),
			.sensed_o(sensor_state[i]));
	end

	bringup_scanner scanner0 (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.pulse_i(scan_pulse),
		.state_i(sensor_state),
		.hold_i(uart_busy),
		.write_o(uart_write),
		.data_o(uart_data));

	uart_tx #(.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)) uart_tx0 (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.write_i(uart_write),
		.data_i(uart_data),
		.busy_o(uart_busy),
		.tx_o(uart_tx_o));

endmodule

`default_nettype wire

//--- testbench/tb_bringup.sv
// runs the short test timing only (scan 4000, baud 8); pin 15 is looped back from drive_o here
`default_nettype none

module tb_bringup;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLOCK_PERIOD = 100;
	localparam int STIM_DELAY = 10;              // after the rising edge
	localparam int RESET_CYCLES = 8;
	localparam int DEC_CLOCKS = 20;
	localparam int SCAN_CLOCKS = 4000;
	localparam int BAUD_CLOCKS = 8;
	localparam int DRIVER_HALF = 5;
	localparam int TOGGLE_EVERY = 4;
	localparam int MODE_PICK = 2000;             // offset of the mode change in each window
	localparam int NUM_REPORTS = 12;
	localparam int REPORT_BYTES = bringup_pkg::REPORT_LEN;
	localparam int SENSE_PINS = bringup_pkg::NUM_PINS - 1;   // the last pin is the loopback
	localparam int TIMEOUT_CYCLES = (NUM_REPORTS + 2) * SCAN_CLOCKS;
	localparam logic [31:0] LFSR_SEED = 32'h8a2c;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic clock;
	logic rst_n_i;
	bringup_pkg::pin_vec_t sense;
	logic drive;
	logic tx_line;

	int cycle;                                    // rising edges since reset release
	logic [31:0] lfsr;
	bit toggling [SENSE_PINS];
	logic pin_level [SENSE_PINS];
	bit window_modes [NUM_REPORTS][SENSE_PINS];   // modes in force at each scan tick
	int value_errors;
	int other_errors;
	int decay_cases;
	int reports_seen;
	bit done;

	bringup_levelshifter #(
		.CLOCKS_PER_DEC(DEC_CLOCKS),
		.CLOCKS_PER_SCAN(SCAN_CLOCKS),
		.CLOCKS_PER_BAUD(BAUD_CLOCKS),
		.DRIVER_HALF(DRIVER_HALF)
	) dut0 (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.sense_i(sense),
		.drive_o(drive),
		.uart_tx_o(tx_line));

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// galois lfsr stepped once per bit
	function automatic logic take_bit();
		lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
		return lfsr[0];
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		value_errors++;
		$display("[FAIL] %s: expected %0h, actual %0h (cycle %0d)", name, expected, actual, cycle);
	endtask

	task automatic pick_modes(input int window);
		bit now_toggling;
		for (int p = 0; p < SENSE_PINS; p++) begin
			now_toggling = take_bit();
			if (!now_toggling)
				pin_level[p] = take_bit();           // static at a random level
			if (toggling[p] && !now_toggling)
				decay_cases++;                       // mark must fall before the tick
			toggling[p] = now_toggling;
			window_modes[window][p] = now_toggling;
		end
	endtask

	task automatic drive_pins();
		for (int p = 0; p < SENSE_PINS; p++) begin
			if (toggling[p] && (cycle % TOGGLE_EVERY) == 0)
				pin_level[p] = ~pin_level[p];
			sense[p] = pin_level[p];
		end
		sense[bringup_pkg::NUM_PINS-1] = drive;   // board loopback
	endtask

	// first inversion DRIVER_HALF cycles after release, then every DRIVER_HALF
	task automatic check_driver();
		logic expected;
		expected = ((cycle / DRIVER_HALF) % 2) == 1;
		if (drive !== expected)
			report_mismatch("driver square wave", int'(expected), int'(drive));
	endtask

	// report line as the model sees it
	function automatic bringup_pkg::byte_t expected_char(input int report, input int pos);
		if (pos < SENSE_PINS)
			return window_modes[report-1][pos] ? bringup_pkg::CHAR_ACTIVE : bringup_pkg::CHAR_IDLE;
		else if (pos == SENSE_PINS)
			return bringup_pkg::CHAR_ACTIVE;     // loopback always toggles
		else if (pos == SENSE_PINS + 1)
			return bringup_pkg::CHAR_CR;
		return bringup_pkg::CHAR_LF;
	endfunction

	// bits sampled mid-bit on the falling edge
	task automatic receive_frame(output bringup_pkg::byte_t data, output int start_cycle);
		bit idle_bad;
		data = '0;
		idle_bad = 1'b0;
		do begin
			@(negedge clock);
			if (tx_line !== 1'b0 && tx_line !== 1'b1 && !idle_bad) begin
				idle_bad = 1'b1;                     // line idles high until the start bit
				other_errors++;
				$display("uart line was not high while idle at cycle %0d", cycle);
			end
		end while (tx_line !== 1'b0);
		start_cycle = cycle;
		repeat (BAUD_CLOCKS / 2) @(negedge clock);
		if (tx_line !== 1'b0) begin
			other_errors++;
			$display("start bit at cycle %0d did not stay low to mid-bit", start_cycle);
		end
		repeat (8) begin
			repeat (BAUD_CLOCKS) @(negedge clock);
			data = {tx_line, data[7:1]};           // lsb first
		end
		repeat (BAUD_CLOCKS) @(negedge clock);
		if (tx_line !== 1'b1) begin
			other_errors++;
			$display("stop bit of the frame from cycle %0d was not high", start_cycle);
		end
	endtask

	initial begin : collect_reports
		bringup_pkg::byte_t data;
		bringup_pkg::byte_t expected;
		int start_cycle;
		string name;
		wait (rst_n_i === 1'b1);
		for (int r = 1; r <= NUM_REPORTS; r++) begin
			for (int b = 0; b < REPORT_BYTES; b++) begin
				receive_frame(data, start_cycle);
				// scan tick to start bit is 2 cycles
				if (b == 0 && start_cycle != r * SCAN_CLOCKS + 2)
					report_mismatch($sformatf("report %0d start cycle", r),
						r * SCAN_CLOCKS + 2, start_cycle);
				expected = expected_char(r, b);
				if (b == SENSE_PINS)
					name = $sformatf("report %0d loopback pin", r);
				else
					name = $sformatf("report %0d byte %0d", r, b);
				if (data !== expected)
					report_mismatch(name, int'(expected), int'(data));
			end
			reports_seen++;
		end
		// line must stay idle for the rest of the last window
		while (cycle < (NUM_REPORTS + 1) * SCAN_CLOCKS) begin
			@(negedge clock);
			if (tx_line !== 1'b1) begin
				other_errors++;
				$display("extra frame started at cycle %0d after the last report", cycle);
				break;
			end
		end
		done = 1'b1;
	end

	initial begin
		clock = 1'b0;
		rst_n_i = 1'b0;
		sense = '0;
		cycle = 0;
		lfsr = LFSR_SEED;
		value_errors = 0;
		other_errors = 0;
		decay_cases = 0;
		reports_seen = 0;
		done = 1'b0;
		for (int p = 0; p < SENSE_PINS; p++) begin
			toggling[p] = 1'b0;
			pin_level[p] = 1'b0;
		end

		repeat (RESET_CYCLES) @(posedge clock);
		#STIM_DELAY;
		rst_n_i = 1'b1;

		while (!done && cycle < TIMEOUT_CYCLES) begin
			@(posedge clock);
			#STIM_DELAY;
			cycle++;
			if ((cycle % SCAN_CLOCKS) == MODE_PICK && (cycle / SCAN_CLOCKS) < NUM_REPORTS)
				pick_modes(cycle / SCAN_CLOCKS);
			drive_pins();
			check_driver();
		end

		if (!done) begin
			other_errors++;
			$display("timeout after %0d cycles with %0d of %0d reports received",
				cycle, reports_seen, NUM_REPORTS);
		end
		if (decay_cases == 0) begin
			other_errors++;
			$display("no pin went from toggling to static, decay was never exercised");
		end

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
verilog/bringup_pkg.sv
verilog/pulse.sv
verilog/bringup_driver.sv
verilog/bringup_sensor.sv
verilog/bringup_scanner.sv
verilog/uart_tx.sv
verilog/bringup_levelshifter.sv
testbench/tb_bringup.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds tb_bringup with Verilator, runs it and exits nonzero on any failure
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	-f sources.f \
	--top-module tb_bringup \
	--Mdir "$BUILD_DIR" \
	-o tb_bringup
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_bringup" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	echo "failure reported, see $LOG"
	exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

exit 0
